/* filelist.f */
+incdir+source
source/otp_buf_pkg.sv
source/secded_72_64_enc.sv
source/ecc_word_check.sv
source/ecc_word_reg.sv
source/ecc_err_collect.sv
source/wb_buf_port.sv
source/otp_buf_top.sv
sim/otp_buf_tb.sv

/* sim/otp_buf_tb.sv */
// Random-stimulus testbench; one 64-bit word per Wishbone transfer, run length bounded by a watchdog.
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_defs.svh"

module otp_buf_tb;

  // Upper bound on bus transfers, used to size the watchdog.
  localparam int TXN_MAX = 128;
  localparam logic [`OTP_BUF_ADR_W-1:0] ADR_STAT = `OTP_BUF_ADR_W'(`OTP_BUF_ADR_STATUS);
  localparam logic [`OTP_BUF_ADR_W-1:0] ADR_INJ  = `OTP_BUF_ADR_W'(`OTP_BUF_ADR_INJECT);

  logic                                    clk_i = 1'b0;
  logic                                    rst_ni;
  logic                                    wb_cyc_i;
  logic                                    wb_stb_i;
  logic                                    wb_we_i;
  logic [`OTP_BUF_ADR_W-1:0]               wb_adr_i;
  otp_buf_pkg::word_t                      wb_dat_i;
  otp_buf_pkg::word_t                      wb_dat_o;
  logic                                    wb_ack_o;
  otp_buf_pkg::word_t [`OTP_BUF_DEPTH-1:0] buf_data_o;
  logic                                    ecc_err_o;

  // Reference model: stored data, per-word state (0 clean, 1 single, 2 double), sticky status.
  otp_buf_pkg::word_t mem_m [`OTP_BUF_DEPTH];
  int                 st_m [`OTP_BUF_DEPTH];
  logic               ss_m;
  logic               sd_m;
  otp_buf_pkg::widx_t fidx_m;

  logic [31:0] lfsr_q = 32'he868;
  string       cur_test;
  int          errors;
  int          checks;
  int          tests;
  int          failed_tests;
  int          err_mark;

  otp_buf_top otp_buf_top_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .buf_data_o(buf_data_o),
    .ecc_err_o (ecc_err_o)
  );

  // 20 ns clock.
  always #10 clk_i = ~clk_i;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken.
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v[i] = lfsr_q[0];
    end
    return v;
  endfunction

  // Mask with k distinct set bits at random positions.
  function automatic otp_buf_pkg::word_t make_mask(input int k);
    otp_buf_pkg::word_t m;
    logic [5:0]         p;
    int                 n;
    m = '0;
    n = 0;
    while (n < k) begin
      p = 6'(rand_bits(6));
      if (!m[p]) begin
        m[p] = 1'b1;
        n++;
      end
    end
    return m;
  endfunction

  // Live flag from the model states.
  function automatic logic model_live();
    logic live;
    live = 1'b0;
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) begin
      if (st_m[k] != 0) live = 1'b1;
    end
    return live;
  endfunction

  // Status word as the register map packs it.
  function automatic otp_buf_pkg::word_t exp_status();
    return {57'd0, fidx_m, 1'b0, sd_m, ss_m, model_live()};
  endfunction

  // Sticky bits accumulate; first index is taken only while nothing is sticky.
  function automatic void update_sticky();
    logic               any_s;
    logic               any_d;
    logic               found;
    otp_buf_pkg::widx_t low;
    any_s = 1'b0;
    any_d = 1'b0;
    found = 1'b0;
    low   = '0;
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) begin
      if (st_m[k] == 1) any_s = 1'b1;
      if (st_m[k] == 2) any_d = 1'b1;
      if (st_m[k] != 0 && !found) begin
        low   = otp_buf_pkg::widx_t'(k);
        found = 1'b1;
      end
    end
    if (found) begin
      if (!ss_m && !sd_m) fidx_m = low;
      ss_m = ss_m | any_s;
      sd_m = sd_m | any_d;
    end
  endfunction

  task automatic compare_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  // One classic cycle. Request held until ack, data sampled mid-cycle.
  task automatic wb_transfer(input logic we_v, input logic [`OTP_BUF_ADR_W-1:0] adr_v,
                             input otp_buf_pkg::word_t dat_v, output otp_buf_pkg::word_t rdat);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we_v;
    wb_adr_i <= adr_v;
    wb_dat_i <= dat_v;
    @(negedge clk_i);
    while (!wb_ack_o) @(negedge clk_i);
    rdat = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic write_reg(input int adr, input otp_buf_pkg::word_t dat);
    otp_buf_pkg::word_t unused;
    wb_transfer(1'b1, `OTP_BUF_ADR_W'(adr), dat, unused);
  endtask

  task automatic read_expect(input int adr, input otp_buf_pkg::word_t exp, input string what);
    otp_buf_pkg::word_t rd;
    wb_transfer(1'b0, `OTP_BUF_ADR_W'(adr), '0, rd);
    compare_val($sformatf("%s@%0d", what, adr), exp, rd);
  endtask

  // Word write with an optional k-bit injected flip, mirrored in the model.
  task automatic write_word(input int idx, input otp_buf_pkg::word_t data, input int k);
    otp_buf_pkg::word_t mask;
    mask = '0;
    if (k > 0) begin
      mask = make_mask(k);
      write_reg(ADR_INJ, mask);
    end
    write_reg(idx, data);
    mem_m[idx] = data ^ mask;
    st_m[idx]  = k;
    update_sticky();
  endtask

  // Direct outputs, sampled away from the clock edge.
  task automatic check_outputs();
    @(negedge clk_i);
    compare_val("ecc_err_o", {63'd0, model_live()}, {63'd0, ecc_err_o});
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) begin
      compare_val($sformatf("buf_data_o[%0d]", k), mem_m[k], buf_data_o[k]);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err_mark) begin
      $display("%s: ok", cur_test);
    end else begin
      failed_tests++;
      $display("%s: %0d mismatches", cur_test, errors - err_mark);
    end
  endtask

  initial begin : p_main
    int idx;
    rst_ni   = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    errors = 0;
    checks = 0;
    tests = 0;
    failed_tests = 0;
    ss_m   = 1'b0;
    sd_m   = 1'b0;
    fidx_m = '0;
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) begin
      mem_m[k] = '0;
      st_m[k]  = 0;
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test("reset_values");
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) read_expect(k, '0, "word");
    read_expect(ADR_STAT, '0, "status");
    read_expect(ADR_INJ, '0, "inject");
    check_outputs();
    end_test();

    start_test("clean_writes");
    repeat (24) begin
      idx = int'(rand_bits(3));
      write_word(idx, rand_bits(64), 0);
    end
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) read_expect(k, mem_m[k], "word");
    read_expect(ADR_STAT, exp_status(), "status");
    check_outputs();
    end_test();

    start_test("single_inject");
    idx = int'(rand_bits(3));
    write_word(idx, rand_bits(64), 1);
    read_expect(idx, mem_m[idx], "word");
    // Clean buffer before, so live and sticky_single are set and first_idx is this word.
    read_expect(ADR_STAT, {57'd0, otp_buf_pkg::widx_t'(idx), 4'b0011}, "status");
    check_outputs();
    end_test();

    start_test("double_inject");
    idx = int'(rand_bits(3));
    write_word(idx, rand_bits(64), 2);
    read_expect(ADR_INJ, '0, "inject");
    read_expect(idx, mem_m[idx], "word");
    read_expect(ADR_STAT, exp_status(), "status");
    // Next write carries no mask.
    idx = int'(rand_bits(3));
    write_word(idx, rand_bits(64), 0);
    read_expect(idx, mem_m[idx], "word");
    check_outputs();
    end_test();

    start_test("repair_and_clear");
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) begin
      if (st_m[k] != 0) write_word(k, rand_bits(64), 0);
    end
    read_expect(ADR_STAT, exp_status(), "status");
    check_outputs();
    write_reg(ADR_STAT, rand_bits(64));
    ss_m   = 1'b0;
    sd_m   = 1'b0;
    fidx_m = '0;
    update_sticky();
    read_expect(ADR_STAT, exp_status(), "status");
    repeat (2) begin
      write_word(int'(rand_bits(3)), rand_bits(64), 1);
      read_expect(ADR_STAT, exp_status(), "status");
    end
    check_outputs();
    end_test();

    start_test("unmapped");
    for (int a = `OTP_BUF_ADR_INJECT + 1; a < (1 << `OTP_BUF_ADR_W); a++) begin
      read_expect(a, '0, "unmapped");
      write_reg(a, rand_bits(64));
    end
    for (int k = 0; k < `OTP_BUF_DEPTH; k++) read_expect(k, mem_m[k], "word");
    check_outputs();
    end_test();

    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Bounds the run by the transfer budget plus margin.
  initial begin : p_watchdog
    repeat (TXN_MAX * 4 + 100) @(posedge clk_i);
    $display("watchdog expired, a bus transfer never received its ack");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* source/ecc_err_collect.sv */
// Sticky error status; sticky bits re-set on the cycle after a clear if an error persists.
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_defs.svh"

module ecc_err_collect (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  otp_buf_pkg::werr_t [`OTP_BUF_DEPTH-1:0] werr_i,
  input  logic                                    clr_i,
  output otp_buf_pkg::err_stat_t                  stat_o
);

  logic                   any_single;
  logic                   any_double;
  otp_buf_pkg::widx_t     low_idx;
  otp_buf_pkg::err_stat_t stat_q;

  // OR-reduce the flags.
  // Scanning downward leaves the lowest failing index.
  always_comb begin : p_reduce
    any_single = 1'b0;
    any_double = 1'b0;
    low_idx    = '0;
    for (int k = `OTP_BUF_DEPTH - 1; k >= 0; k--) begin
      any_single = any_single | werr_i[k][0];
      any_double = any_double | werr_i[k][1];
      if (werr_i[k] != 2'b00) begin
        low_idx = otp_buf_pkg::widx_t'(k);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_stat
    if (!rst_ni) begin
      stat_q <= '0;
    end else begin
      stat_q.live <= any_single | any_double;
      if (clr_i) begin
        stat_q.sticky_single <= 1'b0;
        stat_q.sticky_double <= 1'b0;
        stat_q.first_idx     <= '0;
      end else begin
        stat_q.sticky_single <= stat_q.sticky_single | any_single;
        stat_q.sticky_double <= stat_q.sticky_double | any_double;
        // First failure only while nothing is sticky yet.
        if (!stat_q.sticky_single && !stat_q.sticky_double && (any_single || any_double)) begin
          stat_q.first_idx <= low_idx;
        end
      end
    end
  end

  assign stat_o = stat_q;

endmodule

`default_nettype wire

/* source/ecc_word_check.sv */
// Detection-only SECDED check of one codeword; no corrected data is produced.
`timescale 1ns/1ps
`default_nettype none

module ecc_word_check (
  input  otp_buf_pkg::cw_t   cw_i,
  output otp_buf_pkg::werr_t err_o
);

  // Syndrome over the Hamming positions, and overall parity.
  logic [6:0] syn;
  logic       odd;

  // Walk positions 1 to 71 and XOR in the position of every set bit.
  // Power-of-two positions hold the stored parity bits.
  always_comb begin : p_syndrome
    int unsigned di;
    int unsigned pi;
    logic        bit_v;
    syn = '0;
    di  = 0;
    pi  = 0;
    for (int pos = 1; pos < 72; pos++) begin
      if ((pos & (pos - 1)) == 0) begin
        bit_v = cw_i[64 + pi];
        pi++;
      end else begin
        bit_v = cw_i[di];
        di++;
      end
      if (bit_v) begin
        syn = syn ^ 7'(pos);
      end
    end
  end

  // Odd parity over all 72 bits means an odd number of flips.
  assign odd = ^cw_i;

  // Odd parity is a single error, including a lone overall-bit flip.
  // Even parity with a nonzero syndrome is a double error.
  assign err_o = {(syn != 7'd0) && !odd, odd};

endmodule

`default_nettype wire

/* source/ecc_word_reg.sv */
// Word register file with one shared encoder; the index must address a valid word.
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_defs.svh"

module ecc_word_reg (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  otp_buf_pkg::wr_req_t                     wr_req_i,
  input  otp_buf_pkg::widx_t                       rd_idx_i,
  output otp_buf_pkg::word_t                       rdata_o,
  output otp_buf_pkg::word_t [`OTP_BUF_DEPTH-1:0]  data_o,
  output otp_buf_pkg::werr_t [`OTP_BUF_DEPTH-1:0]  werr_o
);

  // Stored data and check bits.
  otp_buf_pkg::word_t [`OTP_BUF_DEPTH-1:0] data_q;
  otp_buf_pkg::ecc_t  [`OTP_BUF_DEPTH-1:0] ecc_q;

  // Encoded write word, then after injection.
  otp_buf_pkg::cw_t enc_cw;
  otp_buf_pkg::cw_t store_cw;

  // Single encoder for every write.
  secded_72_64_enc u_enc (
    .data_i(wr_req_i.data),
    .cw_o  (enc_cw)
  );

  // Injection flips data bits only, after the check bits are formed.
  assign store_cw = enc_cw ^ {8'h00, wr_req_i.flip};

  // All-zero is a valid codeword for this code.
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      data_q <= '0;
      ecc_q  <= '0;
    end else if (wr_req_i.en) begin
      {ecc_q[wr_req_i.idx], data_q[wr_req_i.idx]} <= store_cw;
    end
  end

  // Read port and concurrent buffer view.
  assign rdata_o = data_q[rd_idx_i];
  assign data_o  = data_q;

  // One checker per stored word, running all the time.
  for (genvar k = 0; k < `OTP_BUF_DEPTH; k++) begin : gen_check
    ecc_word_check u_check (
      .cw_i ({ecc_q[k], data_q[k]}),
      .err_o(werr_o[k])
    );
  end

endmodule

`default_nettype wire

/* source/otp_buf_defs.svh */
// Buffer geometry and register map; depth must stay a power of two matching the index width.
`ifndef OTP_BUF_DEFS_SVH
`define OTP_BUF_DEFS_SVH

// Number of buffered 64-bit words.
`define OTP_BUF_DEPTH 8

// Word index width for the buffer.
`define OTP_BUF_AW 3

// Wishbone word-address width.
`define OTP_BUF_ADR_W 4

// Register map above the word window.
`define OTP_BUF_ADR_STATUS 8
`define OTP_BUF_ADR_INJECT 9

`endif

/* source/otp_buf_pkg.sv */
// Shared types for the buffer; widx_t width follows the index width macro in the defs header.
`default_nettype none

`include "otp_buf_defs.svh"

package otp_buf_pkg;

  // Data, check bits and the full codeword with check bits on top.
  typedef logic [63:0] word_t;
  typedef logic [7:0]  ecc_t;
  typedef logic [71:0] cw_t;

  // Index of one buffered word.
  typedef logic [`OTP_BUF_AW-1:0] widx_t;

  // Checker result. Bit 0 flags a single error, bit 1 a double error.
  typedef logic [1:0] werr_t;

  // One write into the register file, flip is XORed after encoding.
  typedef struct packed {
    logic  en;
    widx_t idx;
    word_t data;
    word_t flip;
  } wr_req_t;

  // Live and sticky error status.
  typedef struct packed {
    logic  live;
    logic  sticky_single;
    logic  sticky_double;
    widx_t first_idx;
  } err_stat_t;

endpackage

`default_nettype wire

/* source/otp_buf_top.sv */
// Buffered OTP partition top; errors are detected and reported, never corrected.
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_defs.svh"

module otp_buf_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    wb_cyc_i,
  input  logic                                    wb_stb_i,
  input  logic                                    wb_we_i,
  input  logic [`OTP_BUF_ADR_W-1:0]               wb_adr_i,
  input  otp_buf_pkg::word_t                      wb_dat_i,
  output otp_buf_pkg::word_t                      wb_dat_o,
  output logic                                    wb_ack_o,
  output otp_buf_pkg::word_t [`OTP_BUF_DEPTH-1:0] buf_data_o,
  output logic                                    ecc_err_o
);

  otp_buf_pkg::wr_req_t                    wr_req;
  otp_buf_pkg::widx_t                      rd_idx;
  otp_buf_pkg::word_t                      rdata;
  otp_buf_pkg::werr_t [`OTP_BUF_DEPTH-1:0] werr;
  otp_buf_pkg::err_stat_t                  stat;
  logic                                    clr;

  // Bus side.
  wb_buf_port u_port (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i (wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o),
    .wr_req_o(wr_req),
    .rd_idx_o(rd_idx),
    .rdata_i (rdata),
    .clr_o   (clr),
    .stat_i  (stat)
  );

  // Protected storage and checkers.
  ecc_word_reg u_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wr_req_i(wr_req),
    .rd_idx_i(rd_idx),
    .rdata_o (rdata),
    .data_o  (buf_data_o),
    .werr_o  (werr)
  );

  // Status from the checker flags.
  ecc_err_collect u_collect (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .werr_i(werr),
    .clr_i (clr),
    .stat_o(stat)
  );

  assign ecc_err_o = stat.live;

endmodule

`default_nettype wire

/* source/secded_72_64_enc.sv */
// Plain (non-inverted) extended Hamming encoder; a zero word gives zero check bits.
`timescale 1ns/1ps
`default_nettype none

module secded_72_64_enc (
  input  otp_buf_pkg::word_t data_i,
  output otp_buf_pkg::cw_t   cw_o
);

  // Seven Hamming parity bits and the overall parity bit.
  logic [6:0] hamm;
  logic       overall;

  // Data bits fill the non-power-of-two positions 3 to 71.
  // Parity bit j covers every position with bit j set.
  always_comb begin : p_hamming
    int unsigned di;
    hamm = '0;
    di   = 0;
    for (int pos = 1; pos < 72; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        for (int j = 0; j < 7; j++) begin
          if (((pos >> j) & 1) != 0) begin
            hamm[j] = hamm[j] ^ data_i[di];
          end
        end
        di++;
      end
    end
  end

  // Overall parity spans data and Hamming bits.
  assign overall = ^{hamm, data_i};

  // Check bits sit above the data.
  assign cw_o = {overall, hamm, data_i};

endmodule

`default_nettype wire

/* source/wb_buf_port.sv */
// Wishbone classic slave with one-cycle ack; the master must hold its request until ack.
`timescale 1ns/1ps
`default_nettype none

`include "otp_buf_defs.svh"

module wb_buf_port (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [`OTP_BUF_ADR_W-1:0]    wb_adr_i,
  input  otp_buf_pkg::word_t           wb_dat_i,
  output otp_buf_pkg::word_t           wb_dat_o,
  output logic                         wb_ack_o,
  output otp_buf_pkg::wr_req_t         wr_req_o,
  output otp_buf_pkg::widx_t           rd_idx_o,
  input  otp_buf_pkg::word_t           rdata_i,
  output logic                         clr_o,
  input  otp_buf_pkg::err_stat_t       stat_i
);

  logic               ack_q;
  logic               req;
  logic               is_word;
  logic               is_stat;
  logic               is_inj;
  otp_buf_pkg::word_t inj_q;
  otp_buf_pkg::word_t rd_mux;
  otp_buf_pkg::word_t dat_q;

  // New request seen while ack is low.
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  // Address decode.
  assign is_word = wb_adr_i < `OTP_BUF_ADR_W'(`OTP_BUF_DEPTH);
  assign is_stat = wb_adr_i == `OTP_BUF_ADR_W'(`OTP_BUF_ADR_STATUS);
  assign is_inj  = wb_adr_i == `OTP_BUF_ADR_W'(`OTP_BUF_ADR_INJECT);

  // Word writes go straight to the register file.
  always_comb begin : p_wr_req
    wr_req_o.en   = req & wb_we_i & is_word;
    wr_req_o.idx  = wb_adr_i[`OTP_BUF_AW-1:0];
    wr_req_o.data = wb_dat_i;
    wr_req_o.flip = inj_q;
  end

  assign rd_idx_o = wb_adr_i[`OTP_BUF_AW-1:0];

  // Any write to status clears the sticky state.
  assign clr_o = req & wb_we_i & is_stat;

  // Read mux. Unmapped addresses return zero.
  always_comb begin : p_rd_mux
    rd_mux = '0;
    if (is_word) begin
      rd_mux = rdata_i;
    end else if (is_stat) begin
      rd_mux = otp_buf_pkg::word_t'({stat_i.first_idx, 1'b0, stat_i.sticky_double,
                                     stat_i.sticky_single, stat_i.live});
    end else if (is_inj) begin
      rd_mux = inj_q;
    end
  end

  // Ack and the one-shot injection mask.
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      ack_q <= 1'b0;
      inj_q <= '0;
    end else begin
      ack_q <= req;
      if (req && wb_we_i && is_inj) begin
        inj_q <= wb_dat_i;
      end else if (wr_req_o.en) begin
        // Mask is spent on this word write.
        inj_q <= '0;
      end
    end
  end

  // Read data is captured with the rising ack.
  always_ff @(posedge clk_i) begin : p_rdata
    if (req) begin
      dat_q <= rd_mux;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule

`default_nettype wire
